// File: Makefile
# Verilator build, run and lint for the ADC fusion testbench

all: run

build:
	verilator --binary --timing --assert -f adc_fusion_top.f --top-module adc_fusion_tb -o adc_fusion_sim

# The log decides pass or fail
run: build
	-./obj_dir/adc_fusion_sim > sim.log 2>&1
	cat sim.log
	grep -q "^PASS: all tests$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f adc_fusion_top.f --top-module adc_fusion_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: adc_fusion_top.f
source/adc_fusion_pkg.sv
source/adc_sample_buffer.sv
source/fixed_to_float.sv
source/pulse_stretch.sv
source/frame_assembler.sv
source/adc_fusion_top.sv
sim/adc_fusion_tb.sv

// File: sim/adc_fusion_tb.sv
/* ADC fusion testbench
   Feeds two frames of samples from the test data file, checks frame writes and irq */

`default_nettype none

module adc_fusion_tb;

    localparam int num_of_board    = 2;
    localparam int irq_width       = 16;
    localparam int clk_period      = 100;
    localparam int channels        = 8;
    localparam int header_len      = 16;
    localparam int samples         = 2 * channels * num_of_board;
    localparam int frame_len       = header_len + samples;
    localparam int num_frames      = 2;
    localparam int timeout_cycles  = 1023;
    localparam int start_delay     = timeout_cycles + 3;
    localparam int frame_cycles    = start_delay + frame_len + irq_width;
    localparam int watchdog_cycles = 2 * frame_cycles + 500;

    localparam logic [31:0] type_word = 32'h1234abcd;

    logic        clk;
    logic        resetn;
    logic [31:0] rtc_sec;
    logic [31:0] rtc_nsec;
    logic        tc_sample_valid    [num_of_board];
    logic [2:0]  tc_sample_channel  [num_of_board];
    logic [23:0] tc_sample_code     [num_of_board];
    logic        rtd_sample_valid   [num_of_board];
    logic [2:0]  rtd_sample_channel [num_of_board];
    logic [23:0] rtd_sample_code    [num_of_board];
    logic        frame_en;
    logic [3:0]  frame_we;
    logic [12:0] frame_addr;
    logic [31:0] frame_din;
    logic        irq;

    // Test data in frame order
    logic [31:0] rtc_sec_data  [num_frames];
    logic [31:0] rtc_nsec_data [num_frames];
    logic [23:0] sample_codes  [num_frames][samples];
    logic [31:0] sample_words  [num_frames][samples];

    // Captured frame memory writes and interrupt edges
    int          wr_count = 0;
    int          wr_cycle [num_frames * frame_len];
    logic [12:0] wr_addr  [num_frames * frame_len];
    logic [31:0] wr_data  [num_frames * frame_len];
    int          irq_rises = 0;
    int          irq_falls = 0;
    int          irq_rise_cycle [num_frames];
    int          irq_fall_cycle [num_frames];
    logic        irq_prev = 1'b0;

    int          cycle = 0;
    logic [15:0] lfsr = 16'd34;

    adc_fusion_top #(
        .num_of_board (num_of_board),
        .irq_width    (irq_width)
    ) u_adc_fusion_top (
        .clk                (clk),
        .resetn             (resetn),
        .rtc_sec            (rtc_sec),
        .rtc_nsec           (rtc_nsec),
        .tc_sample_valid    (tc_sample_valid),
        .tc_sample_channel  (tc_sample_channel),
        .tc_sample_code     (tc_sample_code),
        .rtd_sample_valid   (rtd_sample_valid),
        .rtd_sample_channel (rtd_sample_channel),
        .rtd_sample_code    (rtd_sample_code),
        .frame_en           (frame_en),
        .frame_we           (frame_we),
        .frame_addr         (frame_addr),
        .frame_din          (frame_din),
        .irq                (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------
    // Failure reporting

    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("ERROR at time %0t: %s is 0x%h, expected 0x%h", $time, name, got, want);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_on_failure();
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        report_problem("The run timed out before both frames were written");
    end

    // ------------------------------
    // Fibonacci LFSR for random delays
    // Taps x^16 + x^14 + x^13 + x^11 + 1

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // ------------------------------
    // Test data file

    task automatic read_pair(input int fd, output logic [31:0] a, output logic [31:0] b);
        string line;
        int    n;
        bit    found;
        found = 1'b0;
        while (!found) begin
            n = $fgets(line, fd);
            assert (n != 0) else report_problem("The test data file ended too early");
            // Skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h", a, b);
                assert (n == 2) else report_problem({"Malformed test data line: ", line});
                found = 1'b1;
            end
        end
    endtask

    task automatic load_test_data();
        int          fd;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("sim/adc_fusion_testdata.txt", "r");
        assert (fd != 0) else report_problem("Cannot open sim/adc_fusion_testdata.txt");
        for (int f = 0; f < num_frames; f++) begin
            read_pair(fd, a, b);
            rtc_sec_data[f]  = a;
            rtc_nsec_data[f] = b;
            for (int k = 0; k < samples; k++) begin
                read_pair(fd, a, b);
                sample_codes[f][k] = a[23:0];
                sample_words[f][k] = b;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------
    // Stimulus

    // TC boards start at random offsets and send channels 0 to 7 back to back
    task automatic feed_tc(input int f, output int drdy_cycle);
        int delay [num_of_board];
        int span;
        int ch;
        drdy_cycle = -1;
        span = 0;
        for (int b = 0; b < num_of_board; b++) begin
            draw_bits(6, delay[b]);
            if (delay[b] + channels > span) begin
                span = delay[b] + channels;
            end
        end
        for (int t = 0; t < span; t++) begin
            @(negedge clk);
            for (int b = 0; b < num_of_board; b++) begin
                ch = t - delay[b];
                if (ch >= 0 && ch < channels) begin
                    tc_sample_valid[b]   = 1'b1;
                    tc_sample_channel[b] = 3'(ch);
                    tc_sample_code[b]    = sample_codes[f][b * channels + ch];
                    // Earliest channel 7 gives drdy in the next cycle
                    if (ch == channels - 1 && drdy_cycle < 0) begin
                        drdy_cycle = cycle + 1;
                    end
                end else begin
                    tc_sample_valid[b] = 1'b0;
                end
            end
        end
        @(negedge clk);
        for (int b = 0; b < num_of_board; b++) begin
            tc_sample_valid[b] = 1'b0;
        end
    endtask

    task automatic feed_rtd(input int f);
        for (int b = 0; b < num_of_board; b++) begin
            for (int ch = 0; ch < channels; ch++) begin
                @(negedge clk);
                rtd_sample_valid[b]   = 1'b1;
                rtd_sample_channel[b] = 3'(ch);
                rtd_sample_code[b]    = sample_codes[f][samples / 2 + b * channels + ch];
            end
            @(negedge clk);
            rtd_sample_valid[b] = 1'b0;
        end
    endtask

    // ------------------------------
    // Write monitor sampled mid-cycle

    always @(negedge clk) begin
        if (frame_en === 1'b1) begin
            assert (frame_we == 4'hf) else report_mismatch("frame_we", 32'(frame_we), 32'hf);
            assert (wr_count < num_frames * frame_len)
                else report_problem("The frame memory was written more often than two frames need");
            wr_cycle[wr_count] = cycle;
            wr_addr[wr_count]  = frame_addr;
            wr_data[wr_count]  = frame_din;
            wr_count = wr_count + 1;
        end else begin
            assert (frame_we == 4'h0) else report_mismatch("frame_we", 32'(frame_we), 32'h0);
        end
        if (irq === 1'b1 && !irq_prev) begin
            assert (irq_rises < num_frames)
                else report_problem("An interrupt was raised with no frame behind it");
            irq_rise_cycle[irq_rises] = cycle;
            irq_rises = irq_rises + 1;
        end
        if (irq !== 1'b1 && irq_prev) begin
            irq_fall_cycle[irq_falls] = cycle;
            irq_falls = irq_falls + 1;
        end
        irq_prev = (irq === 1'b1);
    end

    // ------------------------------
    // Frame checks

    function automatic logic [31:0] expected_word(input int f, input int i);
        if (i == 0) return type_word;
        if (i == 1) return 32'(f + 1);
        if (i == 2) return rtc_sec_data[f];
        if (i == 3) return rtc_nsec_data[f];
        if (i < header_len) return 32'h0;
        return sample_words[f][i - header_len];
    endfunction

    task automatic check_frame(input int f, input int drdy_cycle);
        int start;
        int idx;
        start = drdy_cycle + start_delay;
        assert (wr_count == (f + 1) * frame_len)
            else report_problem("The number of frame memory writes is wrong");
        assert (irq_rises == f + 1)
            else report_problem("The number of interrupts does not match the frames");
        for (int i = 0; i < frame_len; i++) begin
            idx = f * frame_len + i;
            assert (wr_cycle[idx] == start + i)
                else report_mismatch("frame_en cycle", 32'(wr_cycle[idx]), 32'(start + i));
            assert (wr_addr[idx] == 13'(4 * i))
                else report_mismatch("frame_addr", 32'(wr_addr[idx]), 32'(4 * i));
            assert (wr_data[idx] == expected_word(f, i))
                else report_mismatch("frame_din", wr_data[idx], expected_word(f, i));
        end
        // irq follows frame_done by one cycle
        assert (irq_rise_cycle[f] == start + frame_len + 1)
            else report_mismatch("irq rise cycle", 32'(irq_rise_cycle[f]),
                                 32'(start + frame_len + 1));
        assert (irq_fall_cycle[f] - irq_rise_cycle[f] == irq_width)
            else report_mismatch("irq width", 32'(irq_fall_cycle[f] - irq_rise_cycle[f]),
                                 32'(irq_width));
    endtask

    // ------------------------------
    // Main sequence

    initial begin
        int drdy_cycle;
        resetn   = 1'b0;
        rtc_sec  = '0;
        rtc_nsec = '0;
        for (int b = 0; b < num_of_board; b++) begin
            tc_sample_valid[b]    = 1'b0;
            tc_sample_channel[b]  = '0;
            tc_sample_code[b]     = '0;
            rtd_sample_valid[b]   = 1'b0;
            rtd_sample_channel[b] = '0;
            rtd_sample_code[b]    = '0;
        end
        load_test_data();
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        assert (frame_en === 1'b0) else report_mismatch("frame_en", 32'(frame_en), 32'h0);
        assert (irq === 1'b0) else report_mismatch("irq", 32'(irq), 32'h0);

        for (int f = 0; f < num_frames; f++) begin
            // RTC stays put through the wait and the frame
            rtc_sec  = rtc_sec_data[f];
            rtc_nsec = rtc_nsec_data[f];
            feed_tc(f, drdy_cycle);
            feed_rtd(f);
            while (irq_falls < f + 1) begin
                @(negedge clk);
            end
            repeat (20) @(negedge clk);
            check_frame(f, drdy_cycle);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/adc_fusion_testdata.txt
# Per frame: one line of rtc_sec rtc_nsec, then 32 lines of offset-binary code and float word
# Sample order: TC board 0 ch 0-7, TC board 1, RTD board 0, RTD board 1 (all hex)
# frame 1
000f4240 05f5e100
800000 00000000
000000 cb000000
ffffff 4afffffe
c00000 4a800000
400000 ca800000
800001 3f800000
7fffff bf800000
800002 40000000
800003 40400000
800004 40800000
800005 40a00000
800006 40c00000
800007 40e00000
800008 41000000
80000a 41200000
800010 41800000
800064 42c80000
8003e8 447a0000
802710 461c4000
8186a0 47c35000
80ffff 477fff00
810000 47800000
800100 43800000
800080 43000000
800200 44000000
7ffffe c0000000
7ffffd c0400000
7fff9c c2c80000
7ffc18 c47a0000
7fd8f0 c61c4000
7e7960 c7c35000
7ffff0 c1800000
# frame 2
000f4241 1dcd6500
123456 cadb9754
abcdef 4a2f37bc
801234 4591a000
000001 cafffffe
400001 ca7ffffc
c00001 4a800002
800055 42aa0000
7fffab c2aa0000
900000 49800000
700000 c9800000
800fff 457ff000
880000 49000000
200000 cac00000
e00000 4ac00000
8000c8 43480000
7fff38 c3480000
80c350 47435000
7f3cb0 c7435000
800000 00000000
ffffff 4afffffe
000000 cb000000
800001 3f800000
7fffff bf800000
c00000 4a800000
800002 40000000
7ffffe c0000000
800010 41800000
7ffff0 c1800000
8003e8 447a0000
7ffc18 c47a0000
8186a0 47c35000
400000 ca800000

// File: source/adc_fusion_pkg.sv
/* ADC fusion shared definitions
   Frame layout, converter timing and the float word views */

`default_nettype none

package adc_fusion_pkg;

    // ------------------------------
    // Frame layout

    localparam logic [31:0] frame_type_word = 32'h1234abcd;

    // Type, sequence, RTC seconds, RTC nanoseconds, then reserved words
    localparam int header_words       = 16;
    localparam int channels_per_board = 8;

    // ------------------------------
    // Timing

    localparam int conv_latency   = 4;
    localparam int timeout_cycles = 1023;

    localparam int sample_code_w = 24;

    // ------------------------------
    // IEEE single precision word

    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } float32_fields_t;

    typedef union packed {
        logic [31:0]     raw;
        float32_fields_t f;
    } float32_u;

endpackage

`default_nettype wire

// File: source/adc_fusion_top.sv
/* ADC data fusion top level
   Per-board TC and RTD buffers, frame assembler, float converter and interrupt */

`default_nettype none

module adc_fusion_top import adc_fusion_pkg::*; #(
    parameter int num_of_board = 6,
    parameter int irq_width    = 16
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [31:0]              rtc_sec,
    input  logic [31:0]              rtc_nsec,
    input  logic                     tc_sample_valid    [num_of_board],
    input  logic [2:0]               tc_sample_channel  [num_of_board],
    input  logic [sample_code_w-1:0] tc_sample_code     [num_of_board],
    input  logic                     rtd_sample_valid   [num_of_board],
    input  logic [2:0]               rtd_sample_channel [num_of_board],
    input  logic [sample_code_w-1:0] rtd_sample_code    [num_of_board],
    output logic                     frame_en,
    output logic [3:0]               frame_we,
    output logic [12:0]              frame_addr,
    output logic [31:0]              frame_din,
    output logic                     irq
);

    logic                     tc_drdy     [num_of_board];
    logic                     tc_rd_en    [num_of_board];
    logic [2:0]               tc_rd_addr  [num_of_board];
    logic [sample_code_w-1:0] tc_rd_data  [num_of_board];
    logic                     rtd_rd_en   [num_of_board];
    logic [2:0]               rtd_rd_addr [num_of_board];
    logic [sample_code_w-1:0] rtd_rd_data [num_of_board];

    logic                            conv_in_valid;
    logic signed [sample_code_w-1:0] conv_in_data;
    logic                            conv_out_valid;
    float32_u                        conv_out_word;
    logic                            frame_done;

    // ------------------------------
    // Sample buffers

    for (genvar i = 0; i < num_of_board; i++) begin : g_board
        adc_sample_buffer u_tc_buffer (
            .clk            (clk),
            .resetn         (resetn),
            .sample_valid   (tc_sample_valid[i]),
            .sample_channel (tc_sample_channel[i]),
            .sample_code    (tc_sample_code[i]),
            .rd_en          (tc_rd_en[i]),
            .rd_addr        (tc_rd_addr[i]),
            .rd_data        (tc_rd_data[i]),
            .drdy           (tc_drdy[i])
        );

        // RTD ready takes no part in start detection
        adc_sample_buffer u_rtd_buffer (
            .clk            (clk),
            .resetn         (resetn),
            .sample_valid   (rtd_sample_valid[i]),
            .sample_channel (rtd_sample_channel[i]),
            .sample_code    (rtd_sample_code[i]),
            .rd_en          (rtd_rd_en[i]),
            .rd_addr        (rtd_rd_addr[i]),
            .rd_data        (rtd_rd_data[i]),
            .drdy           ()
        );
    end

    // ------------------------------
    // Frame path

    frame_assembler #(
        .num_of_board (num_of_board)
    ) u_frame_assembler (
        .clk            (clk),
        .resetn         (resetn),
        .rtc_sec        (rtc_sec),
        .rtc_nsec       (rtc_nsec),
        .tc_drdy        (tc_drdy),
        .tc_rd_data     (tc_rd_data),
        .rtd_rd_data    (rtd_rd_data),
        .tc_rd_en       (tc_rd_en),
        .tc_rd_addr     (tc_rd_addr),
        .rtd_rd_en      (rtd_rd_en),
        .rtd_rd_addr    (rtd_rd_addr),
        .conv_in_valid  (conv_in_valid),
        .conv_in_data   (conv_in_data),
        .conv_out_valid (conv_out_valid),
        .conv_out_word  (conv_out_word),
        .frame_en       (frame_en),
        .frame_we       (frame_we),
        .frame_addr     (frame_addr),
        .frame_din      (frame_din),
        .frame_done     (frame_done)
    );

    fixed_to_float u_fixed_to_float (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (conv_in_valid),
        .in_data   (conv_in_data),
        .out_valid (conv_out_valid),
        .out_word  (conv_out_word)
    );

    pulse_stretch #(
        .width (irq_width)
    ) u_irq_stretch (
        .clk       (clk),
        .resetn    (resetn),
        .pulse_in  (frame_done),
        .pulse_out (irq)
    );

endmodule

`default_nettype wire

// File: source/adc_sample_buffer.sv
/* Sample buffer for one board and one sensor type
   Eight channel codes, data-ready pulse on the last channel, registered read port */

`default_nettype none

module adc_sample_buffer import adc_fusion_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     sample_valid,
    input  logic [2:0]               sample_channel,
    input  logic [sample_code_w-1:0] sample_code,
    input  logic                     rd_en,
    input  logic [2:0]               rd_addr,
    output logic [sample_code_w-1:0] rd_data,
    output logic                     drdy
);

    logic [sample_code_w-1:0] mem [channels_per_board];

    // Sample store
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            mem[sample_channel] <= sample_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Ready once the last channel of a scan lands
    always_ff @(posedge clk) begin
        if (!resetn) begin
            drdy <= 1'b0;
        end else begin
            drdy <= sample_valid && (sample_channel == 3'(channels_per_board - 1));
        end
    end

    // Frame readout and ADC updates never overlap
    a_no_write_during_read: assert property (
        @(posedge clk) disable iff (!resetn) !(sample_valid && rd_en)
    );

endmodule

`default_nettype wire

// File: source/fixed_to_float.sv
/* Signed 24-bit integer to IEEE single precision
   Four-stage pipeline, exact since every magnitude fits the mantissa */

`default_nettype none

module fixed_to_float import adc_fusion_pkg::*; (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            in_valid,
    input  logic signed [sample_code_w-1:0] in_data,
    output logic                            out_valid,
    output float32_u                        out_word
);

    localparam int mag_w = sample_code_w;
    localparam int pos_w = $clog2(mag_w);

    logic [conv_latency-1:0] valid_sr;

    logic             s1_sign;
    logic [mag_w-1:0] s1_mag;

    logic [pos_w-1:0] lead_pos;
    logic             s2_sign;
    logic             s2_nz;
    logic [pos_w-1:0] s2_pos;
    logic [mag_w-1:0] s2_mag;

    logic             s3_sign;
    logic             s3_nz;
    logic [pos_w-1:0] s3_pos;
    logic [mag_w-1:0] s3_norm;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[conv_latency-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[conv_latency-1];

    // ------------------------------
    // Stage 1, sign and magnitude
    always_ff @(posedge clk) begin
        s1_sign <= in_data[mag_w-1];
        s1_mag  <= in_data[mag_w-1] ? $unsigned(-in_data) : $unsigned(in_data);
    end

    // Stage 2, leading one
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < mag_w; i++) begin
            if (s1_mag[i]) begin
                lead_pos = pos_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        s2_sign <= s1_sign;
        s2_nz   <= |s1_mag;
        s2_pos  <= lead_pos;
        s2_mag  <= s1_mag;
    end

    // Stage 3, move the leading one up to the hidden bit
    always_ff @(posedge clk) begin
        s3_sign <= s2_sign;
        s3_nz   <= s2_nz;
        s3_pos  <= s2_pos;
        s3_norm <= s2_mag << (pos_w'(mag_w - 1) - s2_pos);
    end

    // Stage 4, exponent and packing; zero stays all zero
    always_ff @(posedge clk) begin
        out_word.f.sign     <= s3_sign && s3_nz;
        out_word.f.exponent <= s3_nz ? 8'(127 + s3_pos) : 8'd0;
        out_word.f.mantissa <= s3_norm[mag_w-2:0];
    end

endmodule

`default_nettype wire

// File: source/frame_assembler.sv
/* Frame assembler, start detection with timeout, header capture,
   buffer read scheduling and frame memory writes */

`default_nettype none

module frame_assembler import adc_fusion_pkg::*; #(
    parameter int num_of_board = 6
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [31:0]                     rtc_sec,
    input  logic [31:0]                     rtc_nsec,
    input  logic                            tc_drdy     [num_of_board],
    input  logic [sample_code_w-1:0]        tc_rd_data  [num_of_board],
    input  logic [sample_code_w-1:0]        rtd_rd_data [num_of_board],
    output logic                            tc_rd_en    [num_of_board],
    output logic [2:0]                      tc_rd_addr  [num_of_board],
    output logic                            rtd_rd_en   [num_of_board],
    output logic [2:0]                      rtd_rd_addr [num_of_board],
    output logic                            conv_in_valid,
    output logic signed [sample_code_w-1:0] conv_in_data,
    input  logic                            conv_out_valid,
    input  float32_u                        conv_out_word,
    output logic                            frame_en,
    output logic [3:0]                      frame_we,
    output logic [12:0]                     frame_addr,
    output logic [31:0]                     frame_din,
    output logic                            frame_done
);

    localparam int per_type  = channels_per_board * num_of_board;
    localparam int samples   = 2 * per_type;
    localparam int frame_len = header_words + samples;
    localparam int cnt_w     = 11;
    localparam int tmo_w     = $clog2(timeout_cycles + 1);

    // Read issue leads the write by the buffer read, offset register and converter
    localparam int rd_lead   = conv_latency + 2;
    localparam int rd_first  = header_words - rd_lead;
    localparam int mux_first = rd_first + 2;

    localparam logic [cnt_w-1:0] cnt_idle  = '1;
    localparam logic [cnt_w-1:0] len_c     = cnt_w'(frame_len);
    localparam logic [cnt_w-1:0] hdr_c     = cnt_w'(header_words);
    localparam logic [cnt_w-1:0] rd_lo     = cnt_w'(rd_first);
    localparam logic [cnt_w-1:0] rd_hi     = cnt_w'(rd_first + samples);
    localparam logic [cnt_w-1:0] mux_lo    = cnt_w'(mux_first);
    localparam logic [cnt_w-1:0] mux_hi    = cnt_w'(mux_first + samples);
    localparam logic [cnt_w-1:0] per_typ_c = cnt_w'(per_type);

    localparam logic [sample_code_w-1:0] sample_offset = 24'h800000;

    typedef enum logic [1:0] {st_reset, st_idle, st_wait, st_go} state_t;

    state_t           state;
    state_t           next_state;
    logic             any_drdy;
    logic             busy;
    logic             timeout;
    logic             start;
    logic [tmo_w-1:0] tmo_cnt;

    logic [cnt_w-1:0] wr_cnt;
    logic [31:0]      seq_q;
    logic [31:0]      sec_q;
    logic [31:0]      nsec_q;
    logic [31:0]      hdr_din;
    logic             sample_phase;

    logic                     rd_go;
    logic                     rd_rtd;
    int                       rd_board;
    logic [cnt_w-1:0]         rd_s;
    logic                     mux_go;
    logic                     mux_rtd;
    int                       mux_board;
    logic [cnt_w-1:0]         mux_s;
    logic [sample_code_w-1:0] mux_code;

    function automatic int slot_board(input logic [cnt_w-1:0] s);
        logic [cnt_w-1:0] local_s;
        local_s = (s >= per_typ_c) ? s - per_typ_c : s;
        return int'(local_s) / channels_per_board;
    endfunction

    // ------------------------------
    // Start detection

    always_comb begin
        any_drdy = 1'b0;
        for (int i = 0; i < num_of_board; i++) begin
            any_drdy = any_drdy | tc_drdy[i];
        end
    end

    // No new wait while a frame is still streaming
    assign busy = (wr_cnt != cnt_idle);

    always_comb begin
        case (state)
            st_reset: next_state = st_idle;
            st_idle:  next_state = (any_drdy && !busy) ? st_wait : st_idle;
            st_wait:  next_state = timeout ? st_go : st_wait;
            st_go:    next_state = st_idle;
            default:  next_state = st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tmo_cnt <= '0;
        end else if (next_state == st_wait) begin
            tmo_cnt <= timeout ? tmo_cnt : tmo_cnt + 1'b1;
        end else begin
            tmo_cnt <= '0;
        end
    end

    assign timeout = (tmo_cnt == tmo_w'(timeout_cycles));
    assign start   = (state == st_go);

    // ------------------------------
    // Word counter and header

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_cnt <= cnt_idle;
        end else if (start) begin
            wr_cnt <= '0;
        end else if (wr_cnt < len_c) begin
            wr_cnt <= wr_cnt + 1'b1;
        end else begin
            wr_cnt <= cnt_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            seq_q <= '0;
        end else if (start) begin
            seq_q <= seq_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sec_q  <= rtc_sec;
            nsec_q <= rtc_nsec;
        end
    end

    // ------------------------------
    // Buffer reads and offset removal

    assign rd_s     = wr_cnt - rd_lo;
    assign rd_go    = (wr_cnt >= rd_lo) && (wr_cnt < rd_hi);
    assign rd_rtd   = (rd_s >= per_typ_c);
    assign rd_board = slot_board(rd_s);

    for (genvar i = 0; i < num_of_board; i++) begin : g_rd
        always_ff @(posedge clk) begin
            if (!resetn) begin
                tc_rd_en[i]  <= 1'b0;
                rtd_rd_en[i] <= 1'b0;
            end else begin
                tc_rd_en[i]  <= rd_go && !rd_rtd && (rd_board == i);
                rtd_rd_en[i] <= rd_go && rd_rtd && (rd_board == i);
            end
        end

        always_ff @(posedge clk) begin
            tc_rd_addr[i]  <= rd_s[2:0];
            rtd_rd_addr[i] <= rd_s[2:0];
        end
    end

    // Read data is back two counts after the read was scheduled
    assign mux_s     = wr_cnt - mux_lo;
    assign mux_go    = (wr_cnt >= mux_lo) && (wr_cnt < mux_hi);
    assign mux_rtd   = (mux_s >= per_typ_c);
    assign mux_board = slot_board(mux_s);

    always_comb begin
        mux_code = '0;
        if (mux_go) begin
            mux_code = mux_rtd ? rtd_rd_data[mux_board] : tc_rd_data[mux_board];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            conv_in_valid <= 1'b0;
        end else begin
            conv_in_valid <= mux_go;
        end
    end

    // Offset binary to two's complement
    always_ff @(posedge clk) begin
        if (mux_go) begin
            conv_in_data <= $signed(mux_code - sample_offset);
        end
    end

    // ------------------------------
    // Frame memory writes

    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_en     <= 1'b0;
            frame_we     <= 4'h0;
            sample_phase <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            frame_en     <= (wr_cnt < len_c);
            frame_we     <= (wr_cnt < len_c) ? 4'hf : 4'h0;
            sample_phase <= (wr_cnt >= hdr_c) && (wr_cnt < len_c);
            frame_done   <= (wr_cnt == len_c);
        end
    end

    always_ff @(posedge clk) begin
        frame_addr <= {wr_cnt, 2'b00};
        case (wr_cnt)
            11'd0:   hdr_din <= frame_type_word;
            11'd1:   hdr_din <= seq_q;
            11'd2:   hdr_din <= sec_q;
            11'd3:   hdr_din <= nsec_q;
            default: hdr_din <= '0;    // reserved words
        endcase
    end

    // Converter output lands right in the sample write cycle
    assign frame_din = sample_phase ? conv_out_word.raw : hdr_din;

    a_conv_aligned: assert property (
        @(posedge clk) disable iff (!resetn) conv_out_valid == sample_phase
    );

endmodule

`default_nettype wire

// File: source/pulse_stretch.sv
/* Pulse stretcher, holds a one-cycle pulse high for a fixed width */

`default_nettype none

module pulse_stretch #(
    parameter int width = 16
) (
    input  logic clk,
    input  logic resetn,
    input  logic pulse_in,
    output logic pulse_out
);

    localparam int cnt_w = $clog2(width + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (pulse_in) begin
            cnt <= cnt_w'(width);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign pulse_out = (cnt != '0);

    // One frame per interrupt window
    a_no_retrigger: assert property (
        @(posedge clk) disable iff (!resetn) pulse_in |-> (cnt == '0)
    );

endmodule

`default_nettype wire
